//--- source/core_pkg.sv
// ************************************************************
// Shared widths, reset pc, stage-1 FSM states and s1->s2 bundle
// Byte addressing, 32-bit words, no compressed instructions
// ************************************************************

package core_pkg;

    // Plain vector types with a meaning
    typedef logic [31:0] word_t;            // Instruction word
    typedef logic [31:0] addr_t;            // Byte address

    // Program counter constants
    localparam addr_t RESET_PC = 32'h0000_0100;  // First fetch after reset
    localparam addr_t PC_STEP  = 32'd4;          // One word per sequential fetch

    // Stage-1 control FSM states
    typedef enum logic [2:0] {
        INIT,                               // One cycle after reset
        HALT,                               // Sticky until reset
        FETCHING,                           // Normal flow, pc advances
        STALLED_ON_S2_NOEXCEPT,             // Stage 2 busy, clean bundle held
        STALLED_ON_S2_FETCHEXCEPT           // Stage 2 busy, faulting bundle held
    } s1_state_e;

    // Bundle from stage 1 to stage 2, 66 bits
    typedef struct packed {
        logic  valid;                       // Bundle may be taken by stage 2
        addr_t pc;                          // Address of instr
        word_t instr;                       // Zero when fetch_exception is set
        logic  fetch_exception;             // Access fault or misaligned pc
    } s1_to_s2_s;

endpackage : core_pkg

//--- source/core_s1_control.sv
// ************************************************************
// Stage-1 control FSM, outputs decoded from state only
// halt_req wins over everything and HALT is left only by reset
// ************************************************************

`timescale 1ns/1ps

module core_s1_control (
    input  logic clk,
    input  logic rst_n,

    input  logic halt_req,                  // Exit request from later stages
    input  logic s2_busy,                   // Stage 2 cannot take a bundle now
    input  logic fetch_exception,           // Current bundle is faulting

    output logic s1_stall,                  // Freezes pc_ff
    output logic bypass_pc_for_fetch_addr,  // Fetch from next_pc instead of pc_ff
    output logic instr_valid,               // Bundle to stage 2 is valid
    output logic halted                     // Core has stopped
);

    core_pkg::s1_state_e state_ff;
    core_pkg::s1_state_e next_state;

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff <= core_pkg::INIT;     // Exactly one INIT cycle after reset
        end else begin
            state_ff <= next_state;
        end
    end

    // Next-state decode
    always_comb begin
        next_state = core_pkg::HALT;        // Illegal encodings end up here
        if (halt_req) begin
            next_state = core_pkg::HALT;    // Halt from any state
        end else begin
            case (state_ff)
                core_pkg::INIT: begin
                    next_state = core_pkg::FETCHING;  // First fetch already issued
                end
                core_pkg::HALT: begin
                    next_state = core_pkg::HALT;      // No way out but reset
                end
                core_pkg::FETCHING: begin
                    if (s2_busy) begin
                        next_state = fetch_exception ? core_pkg::STALLED_ON_S2_FETCHEXCEPT
                                                     : core_pkg::STALLED_ON_S2_NOEXCEPT;
                    end else begin
                        next_state = core_pkg::FETCHING;  // Keep streaming
                    end
                end
                core_pkg::STALLED_ON_S2_NOEXCEPT,
                core_pkg::STALLED_ON_S2_FETCHEXCEPT: begin
                    next_state = s2_busy ? state_ff : core_pkg::FETCHING;  // Wait for stage 2
                end
                default: begin
                    next_state = core_pkg::HALT;
                end
            endcase
        end
    end

    // Output decode from state_ff
    assign s1_stall                 = (state_ff != core_pkg::FETCHING);
    assign bypass_pc_for_fetch_addr = (state_ff == core_pkg::FETCHING);  // INIT fetches pc_ff
    assign instr_valid              = (state_ff == core_pkg::FETCHING)
                                   || (state_ff == core_pkg::STALLED_ON_S2_NOEXCEPT)
                                   || (state_ff == core_pkg::STALLED_ON_S2_FETCHEXCEPT);
    assign halted                   = (state_ff == core_pkg::HALT);

endmodule : core_s1_control

//--- source/core_s1_pc.sv
// ************************************************************
// Program counter, steps by PC_STEP or takes a redirect target
// Redirect is only honoured while s1_stall is low
// ************************************************************

`timescale 1ns/1ps

module core_s1_pc (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            s1_stall,         // Hold pc_ff
    input  logic            redirect,         // One-cycle strobe from stage 2
    input  core_pkg::addr_t redirect_target,  // May be misaligned

    output core_pkg::addr_t pc,               // Address of the presented bundle
    output core_pkg::addr_t next_pc           // Address fetched when bypassing
);

    core_pkg::addr_t pc_ff;
    core_pkg::addr_t seq_pc;

    // Sequential successor
    assign seq_pc = pc_ff + core_pkg::PC_STEP;  // Wraps at 4 GiB

    // Redirect has priority over stepping
    assign next_pc = redirect ? redirect_target : seq_pc;

    // PC register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_ff <= core_pkg::RESET_PC;
        end else if (!s1_stall) begin
            pc_ff <= next_pc;               // Advance in FETCHING only
        end
    end

    assign pc = pc_ff;

endmodule : core_s1_pc

//--- source/core_s1_fetch.sv
// ************************************************************
// Fetch address select, exception detect and s1->s2 bundle
// Memory data is assumed one cycle after its address
// ************************************************************

`timescale 1ns/1ps

module core_s1_fetch (
    input  logic                bypass_pc_for_fetch_addr,  // Use next_pc
    input  logic                instr_valid,               // From control FSM

    input  core_pkg::addr_t     pc,               // Address of the returning word
    input  core_pkg::addr_t     next_pc,          // Address to issue when streaming

    input  core_pkg::word_t     fetch_data,       // Memory read data
    input  logic                fetch_fault,      // Memory access fault

    output core_pkg::addr_t     fetch_addr,       // To instruction memory
    output logic                fetch_exception,  // Back to control FSM
    output core_pkg::s1_to_s2_s s1_to_s2          // Bundle for stage 2
);

    logic            misaligned;
    logic            exc_valid;
    core_pkg::word_t instr_masked;

    // Streaming issues the successor, otherwise refetch the held pc
    assign fetch_addr = bypass_pc_for_fetch_addr ? next_pc : pc;

    // Word alignment check on the bundle pc
    assign misaligned = (pc[1:0] != 2'b00);

    // Either source raises the exception
    assign fetch_exception = fetch_fault | misaligned;

    // Only a valid bundle reports the exception
    assign exc_valid = instr_valid & fetch_exception;

    // Faulting words never reach decode
    assign instr_masked = exc_valid ? '0 : fetch_data;

    // Bundle assembly
    always_comb begin
        s1_to_s2.valid           = instr_valid;
        s1_to_s2.pc              = pc;
        s1_to_s2.instr           = instr_masked;
        s1_to_s2.fetch_exception = exc_valid;
    end

endmodule : core_s1_fetch

//--- source/core_s1.sv
// ************************************************************
// Stage 1 top. Synchronous instruction memory sits outside
// No handshake beyond s2_busy, redirect held by stage 2 while stalled
// ************************************************************

`timescale 1ns/1ps

module core_s1 (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                halt_req,         // Stop fetching for good
    input  logic                s2_busy,          // Stage 2 back-pressure
    input  logic                redirect,         // Branch or jump taken in stage 2
    input  core_pkg::addr_t     redirect_target,  // New pc on redirect

    input  core_pkg::word_t     fetch_data,       // Memory data, one cycle late
    input  logic                fetch_fault,      // Memory fault, one cycle late

    output core_pkg::addr_t     fetch_addr,       // Memory read address
    output core_pkg::s1_to_s2_s s1_to_s2,         // Bundle to stage 2
    output logic                halted            // Core stopped
);

    logic            s1_stall;
    logic            bypass_pc_for_fetch_addr;
    logic            instr_valid;
    logic            fetch_exception;
    core_pkg::addr_t pc;
    core_pkg::addr_t next_pc;

    // Control FSM
    core_s1_control u_control (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .halt_req                 (halt_req),
        .s2_busy                  (s2_busy),
        .fetch_exception          (fetch_exception),
        .s1_stall                 (s1_stall),
        .bypass_pc_for_fetch_addr (bypass_pc_for_fetch_addr),
        .instr_valid              (instr_valid),
        .halted                   (halted)
    );

    // Program counter
    core_s1_pc u_pc (
        .clk             (clk),
        .rst_n           (rst_n),
        .s1_stall        (s1_stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (pc),
        .next_pc         (next_pc)
    );

    // Fetch address, exception and bundle
    core_s1_fetch u_fetch (
        .bypass_pc_for_fetch_addr (bypass_pc_for_fetch_addr),
        .instr_valid              (instr_valid),
        .pc                       (pc),
        .next_pc                  (next_pc),
        .fetch_data               (fetch_data),
        .fetch_fault              (fetch_fault),
        .fetch_addr               (fetch_addr),
        .fetch_exception          (fetch_exception),
        .s1_to_s2                 (s1_to_s2)
    );

endmodule : core_s1

//--- dv/tb_clk_gen.sv
// ************************************************************
// Free-running 20 ns clock, power-on reset low for 10 cycles
// ************************************************************

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int CLK_PERIOD_NS = 20;      // 50 MHz
    localparam int RESET_CYCLES  = 10;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after an edge so the first cycle starts cleanly
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule : tb_clk_gen

//--- dv/tb_core_s1.sv
// ************************************************************
// Stage-1 testbench applying one golden line per cycle after power-on reset
// Memory returns the inverted address one cycle late
// ************************************************************

`timescale 1ns/1ps

module tb_core_s1;

    localparam int    CLK_PERIOD_NS  = 20;
    localparam int    DRIVE_DELAY_NS = 1;           // Inputs change after the edge
    localparam int    TIMEOUT_MARGIN = 20;          // Extra cycles beyond the golden file
    localparam string GOLDEN_FILE    = "dv/core_s1_golden.txt";

    // Golden line with stimulus first and expected outputs after
    typedef struct packed {
        logic            rst;
        logic            halt_req;
        logic            s2_busy;
        logic            redirect;
        core_pkg::addr_t redirect_target;
        logic            fetch_fault;
        logic            exp_valid;
        core_pkg::addr_t exp_pc;
        logic            exp_exception;
        logic            exp_halted;
        core_pkg::addr_t exp_fetch_addr;
    } golden_line_s;

    logic                clk;
    logic                rst_n;                     // Power-on reset
    logic                line_rst;                  // Reset requested by the golden file
    logic                dut_rst_n;
    logic                halt_req;
    logic                s2_busy;
    logic                redirect;
    core_pkg::addr_t     redirect_target;
    core_pkg::word_t     fetch_data;
    logic                fetch_fault;
    core_pkg::addr_t     fetch_addr;
    core_pkg::s1_to_s2_s s1_to_s2;
    logic                halted;

    core_pkg::addr_t     mem_addr;                  // Address held by the memory model
    golden_line_s        golden_q[$];
    int                  errors;
    int                  checks;
    int                  cycle_count;
    int                  cycle_limit;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    assign dut_rst_n = rst_n & ~line_rst;

    core_s1 UUT (
        .clk             (clk),
        .rst_n           (dut_rst_n),
        .halt_req        (halt_req),
        .s2_busy         (s2_busy),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .fetch_data      (fetch_data),
        .fetch_fault     (fetch_fault),
        .fetch_addr      (fetch_addr),
        .s1_to_s2        (s1_to_s2),
        .halted          (halted)
    );

    // Synchronous instruction memory returning the inverse of the address
    initial begin
        fetch_data = '0;
        forever begin
            @(posedge clk);
            mem_addr = fetch_addr;                  // Address of the cycle just ended
            #(DRIVE_DELAY_NS);
            fetch_data = ~mem_addr;
        end
    end

    task automatic init_inputs();
        line_rst        = 1'b0;
        halt_req        = 1'b0;
        s2_busy         = 1'b0;
        redirect        = 1'b0;
        redirect_target = '0;
        fetch_fault     = 1'b0;
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] rst_f, halt_f, busy_f, redir_f, target_f, fault_f;
        logic [31:0] valid_f, pc_f, exc_f, halted_f, faddr_f;
        golden_line_s g;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the golden file %s", GOLDEN_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 1 || line.getc(0) == "#") continue;  // Blank or column header
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", rst_f, halt_f, busy_f,
                        redir_f, target_f, fault_f, valid_f, pc_f, exc_f, halted_f, faddr_f);
            if (n != 11) begin
                errors++;
                $display("Golden file line cannot be parsed: %s", line);
                continue;
            end
            g.rst             = rst_f[0];
            g.halt_req        = halt_f[0];
            g.s2_busy         = busy_f[0];
            g.redirect        = redir_f[0];
            g.redirect_target = target_f;
            g.fetch_fault     = fault_f[0];
            g.exp_valid       = valid_f[0];
            g.exp_pc          = pc_f;
            g.exp_exception   = exc_f[0];
            g.exp_halted      = halted_f[0];
            g.exp_fetch_addr  = faddr_f;
            golden_q.push_back(g);
        end
        $fclose(fd);
    endtask

    task automatic drive_line(input golden_line_s g);
        line_rst        = g.rst;
        halt_req        = g.halt_req;
        s2_busy         = g.s2_busy;
        redirect        = g.redirect;
        redirect_target = g.redirect_target;
        fetch_fault     = g.fetch_fault;
    endtask

    task automatic check_field(input int idx, input string name,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED line %0d %s: expected %h, got %h", idx, name, expected, actual);
        end
    endtask

    task automatic compare_outputs(input int idx, input golden_line_s g);
        core_pkg::s1_to_s2_s exp_bundle;
        exp_bundle.valid           = g.exp_valid;
        exp_bundle.pc              = g.exp_pc;
        exp_bundle.fetch_exception = g.exp_exception;
        exp_bundle.instr           = g.exp_exception ? '0 : ~g.exp_pc;  // Masked on a fault
        check_field(idx, "fetch_addr", g.exp_fetch_addr, fetch_addr);
        check_field(idx, "halted", 32'(g.exp_halted), 32'(halted));
        check_field(idx, "s1_to_s2.valid", 32'(exp_bundle.valid), 32'(s1_to_s2.valid));
        check_field(idx, "s1_to_s2.pc", exp_bundle.pc, s1_to_s2.pc);
        check_field(idx, "s1_to_s2.fetch_exception", 32'(exp_bundle.fetch_exception),
                    32'(s1_to_s2.fetch_exception));
        if (exp_bundle.valid) begin
            check_field(idx, "s1_to_s2.instr", exp_bundle.instr, s1_to_s2.instr);
        end
    endtask

    // Watchdog on cycles after power-on reset
    initial begin
        cycle_count = 0;
        wait (rst_n === 1'b1);
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Errors: %0d, checks: %0d", errors, checks);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        init_inputs();
        load_golden();
        cycle_limit = golden_q.size() + TIMEOUT_MARGIN;
        if (golden_q.size() == 0) begin
            errors++;
            $display("No stimulus lines were read from the golden file");
        end
        @(posedge rst_n);                           // Already DRIVE_DELAY_NS past the edge
        checks++;
        assert (s1_to_s2.pc === core_pkg::RESET_PC) else begin  // pc_ff reset value
            errors++;
            $display("FAILED at reset release s1_to_s2.pc: expected %h, got %h",
                     core_pkg::RESET_PC, s1_to_s2.pc);
        end
        foreach (golden_q[i]) begin
            drive_line(golden_q[i]);
            #(CLK_PERIOD_NS - DRIVE_DELAY_NS - 1);  // Sample 1 ns before the next edge
            compare_outputs(i, golden_q[i]);
            @(posedge clk);
            #(DRIVE_DELAY_NS);
        end
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_core_s1

//--- dv/core_s1_golden.txt
# rst halt_req s2_busy redirect redirect_target fetch_fault  valid pc exception halted fetch_addr
# One line per cycle after power-on reset, all hex, rst holds reset low for that cycle
0 0 0 0 00000000 0  0 00000100 0 0 00000100
0 0 0 0 00000000 0  1 00000100 0 0 00000104
0 0 0 0 00000000 0  1 00000104 0 0 00000108
0 0 0 0 00000000 0  1 00000108 0 0 0000010c
0 0 0 0 00000000 0  1 0000010c 0 0 00000110
0 0 1 0 00000000 0  1 00000110 0 0 00000114
0 0 1 0 00000000 0  1 00000114 0 0 00000114
0 0 1 0 00000000 0  1 00000114 0 0 00000114
0 0 0 0 00000000 0  1 00000114 0 0 00000114
0 0 0 0 00000000 0  1 00000114 0 0 00000118
0 0 0 0 00000000 0  1 00000118 0 0 0000011c
0 0 0 1 00000200 0  1 0000011c 0 0 00000200
0 0 0 0 00000000 0  1 00000200 0 0 00000204
0 0 0 0 00000000 0  1 00000204 0 0 00000208
0 0 0 0 00000000 1  1 00000208 1 0 0000020c
0 0 0 0 00000000 0  1 0000020c 0 0 00000210
0 0 0 1 00000302 0  1 00000210 0 0 00000302
0 0 0 0 00000000 0  1 00000302 1 0 00000306
0 0 0 1 00000400 0  1 00000306 1 0 00000400
0 0 0 0 00000000 0  1 00000400 0 0 00000404
0 0 1 0 00000000 1  1 00000404 1 0 00000408
0 0 1 0 00000000 1  1 00000408 1 0 00000408
0 0 1 0 00000000 1  1 00000408 1 0 00000408
0 0 0 0 00000000 1  1 00000408 1 0 00000408
0 0 0 0 00000000 0  1 00000408 0 0 0000040c
0 0 0 0 00000000 0  1 0000040c 0 0 00000410
0 0 0 1 00000502 0  1 00000410 0 0 00000502
0 0 1 0 00000000 0  1 00000502 1 0 00000506
0 0 1 0 00000000 0  1 00000506 1 0 00000506
0 0 1 1 00000600 0  1 00000506 1 0 00000506
0 0 0 1 00000600 0  1 00000506 1 0 00000506
0 0 0 1 00000600 0  1 00000506 1 0 00000600
0 0 0 0 00000000 0  1 00000600 0 0 00000604
0 1 0 0 00000000 0  1 00000604 0 0 00000608
0 0 1 0 00000000 0  0 00000608 0 1 00000608
0 0 0 1 00000700 0  0 00000608 0 1 00000608
0 0 0 0 00000000 1  0 00000608 0 1 00000608
1 0 0 0 00000000 0  0 00000100 0 0 00000100
0 0 0 0 00000000 0  0 00000100 0 0 00000100
0 0 0 0 00000000 0  1 00000100 0 0 00000104
0 0 1 0 00000000 0  1 00000104 0 0 00000108
0 1 1 0 00000000 0  1 00000108 0 0 00000108
0 0 1 0 00000000 0  0 00000108 0 1 00000108
0 0 0 1 00000800 0  0 00000108 0 1 00000108
0 0 1 0 00000000 0  0 00000108 0 1 00000108
0 0 0 0 00000000 0  0 00000108 0 1 00000108

//--- verilog.f
source/core_pkg.sv
source/core_s1_control.sv
source/core_s1_pc.sv
source/core_s1_fetch.sv
source/core_s1.sv
dv/tb_clk_gen.sv
dv/tb_core_s1.sv

//--- run.sh
#!/bin/sh
# Build and run the stage-1 testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f verilog.f --top-module tb_core_s1 \
    -o sim_tb_core_s1 > "$LOG" 2>&1 \
    && ./obj_dir/sim_tb_core_s1 2>&1 | tee -a "$LOG" \
    || { echo "Build or simulation did not complete, see $LOG"; exit 1; }

grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }
